// ==== verilog.f ====
hw/synth_pkg.sv
hw/timing_gen.sv
hw/synth_clk_gen.sv
hw/osc_phase_stage.sv
hw/wave_env_stage.sv
hw/frame_mixer.sv
hw/synth_core_top.sv
verif/synth_core_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = synth_core_tb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only -Wall --timing
OBJ      = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ) -o V$(TOP)

run: build
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ)

// ==== verif/synth_core_tb.sv ====
module synth_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import synth_pkg::*;

    localparam int MAX_FRAMES  = 66;   // 1 + 5 + 10 + 6 + 40 + 4 triggers at most
    localparam int CFG_WRITES  = 23;   // 2 + 16 + 5
    localparam int CYCLE_LIMIT = 60 * MAX_FRAMES + 8 * CFG_WRITES + 200;
    localparam int TRIG_PULSES = 40;   // trigger storm length

    logic      AUDIO_CLK;
    logic      reset_reg_N;
    logic      trig;
    logic      cfg_valid;
    cfg_sel_e  cfg_sel;
    slot_idx_t cfg_slot;
    phase_t    cfg_data;
    logic      sample_ready;
    logic      cfg_ready;
    logic      sample_valid;
    sample_t   sample;

    logic [15:0] inc_m   [SLOTS];    // model increments
    logic [7:0]  lvl_m   [SLOTS];    // model levels
    logic [15:0] phase_m [SLOTS];    // model accumulators
    logic [15:0] exp_q   [$];        // expected samples in arrival order

    int          seed = 44;
    int          check_count = 0;
    int          err_count = 0;
    int          rx_count = 0;
    int          cycle_count = 0;
    int          test_err_base = 0;
    int          stall_left = 0;
    logic        stall_mode = 1'b0;  // random sample_ready when set
    logic        hold_pending = 1'b0;
    logic [15:0] held_sample = '0;

    synth_core_top dut0 (
        .AUDIO_CLK    (AUDIO_CLK),
        .reset_reg_N  (reset_reg_N),
        .trig         (trig),
        .cfg_valid    (cfg_valid),
        .cfg_sel      (cfg_sel),
        .cfg_slot     (cfg_slot),
        .cfg_data     (cfg_data),
        .sample_ready (sample_ready),
        .cfg_ready    (cfg_ready),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    initial
    begin
        AUDIO_CLK = 1'b0;
        forever #4 AUDIO_CLK = ~AUDIO_CLK;   // 8 ns period
    end

    // every phase steps once then saw x level >>> 8 is summed and >>> 3
    function automatic logic [15:0] frame_sample();
        int acc;
        int saw;
        acc = 0;
        for (int s = 0; s < SLOTS; s++)
        begin
            phase_m[s] = phase_m[s] + inc_m[s];        // wraps mod 2^16
            saw = $signed(phase_m[s]);                  // phase read as signed saw
            acc = acc + ((saw * int'(lvl_m[s])) >>> 8);
        end
        return 16'(acc >>> SLOT_W);                     // average over 8 slots
    endfunction

    task automatic step();
        @(posedge AUDIO_CLK);
        #1;                                             // drive just after the edge
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic end_test(string name);
        $display("%s done, %0d errors", name, err_count - test_err_base);
        test_err_base = err_count;
    endtask

    task automatic write_cfg(cfg_sel_e sel, int slot, logic [15:0] data);
        while (!cfg_ready)
            step();
        cfg_valid = 1'b1;
        cfg_sel   = sel;
        cfg_slot  = slot_idx_t'(slot);
        cfg_data  = data;
        if (sel == CFG_INC)
            inc_m[slot] = data;
        else
            lvl_m[slot] = data[7:0];                    // high byte ignored
        step();
        cfg_valid = 1'b0;
    endtask

    // rising trig while idle with the expected sample queued at once
    task automatic fire_trigger();
        while (!cfg_ready)
            step();
        trig = 1'b1;
        exp_q.push_back(frame_sample());
        step();
        trig = 1'b0;
        step();                                         // low again before next edge
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || !cfg_ready)
            step();
    endtask

    // sample_ready driver with long random stalls in stall mode
    always @(posedge AUDIO_CLK)
    begin
        #1;
        if (!stall_mode)
            sample_ready = 1'b1;
        else if (stall_left > 0)
        begin
            sample_ready = 1'b0;
            stall_left--;
        end
        else
        begin
            sample_ready = 1'b1;
            stall_left = $random(seed) & 31;            // up to 31 cycles
        end
    end

    // compare on handshake plus hold and cfg_ready rules while valid
    always @(posedge AUDIO_CLK)
    begin
        if (reset_reg_N)
        begin
            if (hold_pending)
            begin
                check_value("sample_valid", 32'(sample_valid), 32'd1);
                check_value("sample", 32'($unsigned(sample)), 32'(held_sample));
            end
            if (sample_valid)
                check_value("cfg_ready", 32'(cfg_ready), 32'd0);   // frame still open
            if (sample_valid && sample_ready)
            begin
                rx_count++;
                if (exp_q.size() == 0)
                begin
                    err_count++;
                    $display("sample 0x%0h taken with no frame pending", sample);
                end
                else
                    check_value("sample", 32'($unsigned(sample)), 32'(exp_q.pop_front()));
            end
            hold_pending = sample_valid && !sample_ready;
            held_sample  = $unsigned(sample);
        end
    end

    always @(posedge AUDIO_CLK)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, %0d samples never arrived",
                     cycle_count, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        int base_rx;
        int taken;
        int dropped;
        trig         = 1'b0;
        cfg_valid    = 1'b0;
        cfg_sel      = CFG_INC;
        cfg_slot     = '0;
        cfg_data     = '0;
        sample_ready = 1'b1;
        reset_reg_N  = 1'b0;
        for (int s = 0; s < SLOTS; s++)
        begin
            inc_m[s]   = '0;
            lvl_m[s]   = '0;
            phase_m[s] = '0;
        end
        repeat (2) @(posedge AUDIO_CLK);
        #1;
        reset_reg_N = 1'b1;

        check_value("sample_valid", 32'(sample_valid), 32'd0);
        check_value("cfg_ready", 32'(cfg_ready), 32'd1);
        fire_trigger();                                 // all levels 0 so sample 0
        wait_drain();
        end_test("test 1 reset");

        write_cfg(CFG_INC, 3, 16'h3456);
        write_cfg(CFG_LEVEL, 3, 16'h00c0);
        repeat (5) fire_trigger();                      // phase wraps through negative saw
        wait_drain();
        end_test("test 2 single slot");

        for (int s = 0; s < SLOTS; s++)
        begin
            write_cfg(CFG_INC, s, 16'($random(seed)));
            write_cfg(CFG_LEVEL, s, 16'($random(seed)));   // junk high byte too
        end
        repeat (10) fire_trigger();
        wait_drain();
        end_test("test 3 all slots");

        stall_mode = 1'b1;
        repeat (6) fire_trigger();
        wait_drain();
        stall_mode = 1'b0;
        step();
        end_test("test 4 back-pressure");

        base_rx = rx_count;
        taken   = 0;
        dropped = 0;
        for (int p = 0; p < TRIG_PULSES; p++)
        begin
            trig = 1'b1;
            if (cfg_ready)
            begin
                exp_q.push_back(frame_sample());        // edge lands in idle
                taken++;
            end
            else
                dropped++;
            step();
            trig = 1'b0;
            repeat (1 + ($random(seed) & 3)) step();
        end
        wait_drain();
        check_value("sample count", 32'(rx_count - base_rx), 32'(taken));
        if (dropped == 0)
        begin
            err_count++;
            $display("no trigger fell inside a running frame");
        end
        end_test("test 5 triggers in frame");

        write_cfg(CFG_INC, 0, 16'h0400);
        write_cfg(CFG_LEVEL, 0, 16'h00ff);
        write_cfg(CFG_INC, 5, 16'h0000);                // slot 5 phase frozen
        write_cfg(CFG_LEVEL, 7, 16'h0000);              // slot 7 muted
        repeat (2) fire_trigger();
        wait_drain();
        write_cfg(CFG_INC, 2, 16'h8001);                // phases carry on
        repeat (2) fire_trigger();
        wait_drain();
        end_test("test 6 config between");

        $display("checks %0d, errors %0d, samples %0d", check_count, err_count, rx_count);
        if (err_count == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/synth_core_top.sv ====
module synth_core_top (
    input  logic                 AUDIO_CLK,
    input  logic                 reset_reg_N,
    input  logic                 trig,
    input  logic                 cfg_valid,
    input  synth_pkg::cfg_sel_e  cfg_sel,
    input  synth_pkg::slot_idx_t cfg_slot,
    input  synth_pkg::phase_t    cfg_data,
    input  logic                 sample_ready,
    output logic                 cfg_ready,
    output logic                 sample_valid,
    output synth_pkg::sample_t   sample
);
    import synth_pkg::*;

    logic      slot_stb;
    slot_idx_t slot_idx;
    logic      osc_valid;
    slot_idx_t osc_slot;
    phase_t    osc_phase;
    logic      wave_valid;
    slot_idx_t wave_slot;
    sample_t   wave_val;
    logic      frame_done;

    synth_clk_gen synth_clk_gen_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .trig        (trig),
        .frame_done  (frame_done),
        .slot_stb    (slot_stb),
        .slot_idx    (slot_idx),
        .cfg_ready   (cfg_ready)
    );

    osc_phase_stage osc_phase_stage_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .slot_stb    (slot_stb),
        .slot_idx    (slot_idx),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .cfg_sel     (cfg_sel),
        .cfg_slot    (cfg_slot),
        .cfg_data    (cfg_data),
        .osc_valid   (osc_valid),
        .osc_slot    (osc_slot),
        .osc_phase   (osc_phase)
    );

    wave_env_stage wave_env_stage_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .osc_valid   (osc_valid),
        .osc_slot    (osc_slot),
        .osc_phase   (osc_phase),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .cfg_sel     (cfg_sel),
        .cfg_slot    (cfg_slot),
        .cfg_data    (cfg_data),
        .wave_valid  (wave_valid),
        .wave_slot   (wave_slot),
        .wave_val    (wave_val)
    );

    frame_mixer frame_mixer_inst (
        .AUDIO_CLK    (AUDIO_CLK),
        .reset_reg_N  (reset_reg_N),
        .wave_valid   (wave_valid),
        .wave_slot    (wave_slot),
        .wave_val     (wave_val),
        .sample_ready (sample_ready),
        .sample_valid (sample_valid),
        .sample       (sample),
        .frame_done   (frame_done)
    );

endmodule

// ==== hw/frame_mixer.sv ====
module frame_mixer (
    input  logic                 AUDIO_CLK,
    input  logic                 reset_reg_N,
    input  logic                 wave_valid,
    input  synth_pkg::slot_idx_t wave_slot,
    input  synth_pkg::sample_t   wave_val,
    input  logic                 sample_ready,
    output logic                 sample_valid,
    output synth_pkg::sample_t   sample,
    output logic                 frame_done
);
    import synth_pkg::*;

    mix_t mix_acc;     // running frame sum
    mix_t mix_sum;
    mix_t wave_ext;
    logic last_slot;

    assign wave_ext   = {{SLOT_W{wave_val[SAMPLE_W-1]}}, wave_val};   // sign extend
    assign mix_sum    = ((wave_slot == '0) ? mix_t'(0) : mix_acc) + wave_ext;  // slot 0 restarts
    assign last_slot  = wave_valid && (wave_slot == slot_idx_t'(SLOTS - 1));
    assign frame_done = sample_valid && sample_ready;   // handshake cycle

    always_ff @(posedge AUDIO_CLK)
    begin
        if (wave_valid)
        begin
            mix_acc <= mix_sum;
        end
        if (last_slot)
        begin
            sample <= mix_sum[MIX_W-1:SLOT_W];   // average over SLOTS
        end
    end

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            sample_valid <= 1'b0;
        end
        else if (last_slot)
        begin
            sample_valid <= 1'b1;                // next frame waits for handshake
        end
        else if (frame_done)
        begin
            sample_valid <= 1'b0;
        end
    end

    // held sample must not move under back-pressure
    a_sample_hold: assert property (
        @(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample)
    );

endmodule

// ==== hw/wave_env_stage.sv ====
module wave_env_stage (
    input  logic                 AUDIO_CLK,
    input  logic                 reset_reg_N,
    input  logic                 osc_valid,
    input  synth_pkg::slot_idx_t osc_slot,
    input  synth_pkg::phase_t    osc_phase,
    input  logic                 cfg_valid,
    input  logic                 cfg_ready,
    input  synth_pkg::cfg_sel_e  cfg_sel,
    input  synth_pkg::slot_idx_t cfg_slot,
    input  synth_pkg::phase_t    cfg_data,
    output logic                 wave_valid,
    output synth_pkg::slot_idx_t wave_slot,
    output synth_pkg::sample_t   wave_val
);
    import synth_pkg::*;

    level_t                  level_mem [SLOTS];   // per-slot gain
    logic                    level_wr;
    sample_t                 saw;
    logic signed [LEVEL_W:0] level_s;             // zero-extended, signed
    prod_t                   prod;

    assign level_wr = cfg_valid && cfg_ready && (cfg_sel == CFG_LEVEL);
    assign saw      = osc_phase;                  // phase bits read as signed saw
    assign level_s  = {1'b0, level_mem[osc_slot]};
    assign prod     = saw * level_s;              // signed x unsigned level

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            for (int i = 0; i < SLOTS; i++)
            begin
                level_mem[i] <= '0;
            end
        end
        else if (level_wr)
        begin
            level_mem[cfg_slot] <= cfg_data[LEVEL_W-1:0];   // low byte only
        end
    end

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            wave_valid <= 1'b0;
        end
        else
        begin
            wave_valid <= osc_valid;
        end
    end

    always_ff @(posedge AUDIO_CLK)
    begin
        if (osc_valid)
        begin
            wave_slot <= osc_slot;
            wave_val  <= prod[LEVEL_W +: SAMPLE_W];   // >>> 8, always fits 16 bits
        end
    end

endmodule

// ==== hw/osc_phase_stage.sv ====
module osc_phase_stage (
    input  logic                 AUDIO_CLK,
    input  logic                 reset_reg_N,
    input  logic                 slot_stb,
    input  synth_pkg::slot_idx_t slot_idx,
    input  logic                 cfg_valid,
    input  logic                 cfg_ready,
    input  synth_pkg::cfg_sel_e  cfg_sel,
    input  synth_pkg::slot_idx_t cfg_slot,
    input  synth_pkg::phase_t    cfg_data,
    output logic                 osc_valid,
    output synth_pkg::slot_idx_t osc_slot,
    output synth_pkg::phase_t    osc_phase
);
    import synth_pkg::*;

    phase_t inc_mem   [SLOTS];   // per-slot increment
    phase_t phase_mem [SLOTS];   // per-slot accumulator
    phase_t phase_sum;
    logic   inc_wr;

    assign inc_wr    = cfg_valid && cfg_ready && (cfg_sel == CFG_INC);
    assign phase_sum = phase_mem[slot_idx] + inc_mem[slot_idx];   // wraps mod 2^16

    // cfg only in IDLE, strobes only in RUN, so no port clash
    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            for (int i = 0; i < SLOTS; i++)
            begin
                inc_mem[i]   <= '0;
                phase_mem[i] <= '0;
            end
        end
        else
        begin
            if (inc_wr)
            begin
                inc_mem[cfg_slot] <= cfg_data;
            end
            if (slot_stb)
            begin
                phase_mem[slot_idx] <= phase_sum;   // kept across frames
            end
        end
    end

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            osc_valid <= 1'b0;
        end
        else
        begin
            osc_valid <= slot_stb;                  // one clock behind strobe
        end
    end

    // payload, only loaded on a strobe
    always_ff @(posedge AUDIO_CLK)
    begin
        if (slot_stb)
        begin
            osc_slot  <= slot_idx;
            osc_phase <= phase_sum;                 // new phase goes downstream
        end
    end

endmodule

// ==== hw/synth_clk_gen.sv ====
module synth_clk_gen (
    input  logic                 AUDIO_CLK,
    input  logic                 reset_reg_N,
    input  logic                 trig,        // level, edge detected here
    input  logic                 frame_done,  // sample taken downstream
    output logic                 slot_stb,
    output synth_pkg::slot_idx_t slot_idx,
    output logic                 cfg_ready
);
    import synth_pkg::*;

    run_state_e state;
    logic       trig_dly;
    logic       trig_rising;
    logic       last_stb;
    div_cnt_t   div_cnt;
    logic       slot_zero;
    logic       slot_top;

    assign trig_rising = trig && !trig_dly;
    assign last_stb    = slot_stb && slot_top;   // strobe of the top slot
    assign cfg_ready   = (state == IDLE);        // config only between frames

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            trig_dly <= 1'b0;
        end
        else
        begin
            trig_dly <= trig;
        end
    end

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:    if (trig_rising) state <= RUN;    // edges elsewhere dropped
                RUN:     if (last_stb)    state <= DRAIN;
                DRAIN:   if (frame_done)  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // divider, first strobe SLOT_DIV clocks into RUN
    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            div_cnt  <= '0;
            slot_stb <= 1'b0;
        end
        else if (state == RUN && !last_stb)
        begin
            if (div_cnt == div_cnt_t'(SLOT_DIV - 1))
            begin
                div_cnt  <= '0;
                slot_stb <= 1'b1;
            end
            else
            begin
                div_cnt  <= div_cnt_t'(div_cnt + 1'b1);
                slot_stb <= 1'b0;
            end
        end
        else
        begin
            div_cnt  <= '0;                      // restart phase for next frame
            slot_stb <= 1'b0;
        end
    end

    timing_gen timing_gen_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .slot_stb    (slot_stb),
        .slot_idx    (slot_idx),
        .slot_zero   (slot_zero),
        .slot_top    (slot_top)
    );

    a_stb_in_run: assert property (
        @(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        slot_stb |-> state == RUN
    );

    a_done_in_drain: assert property (
        @(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        frame_done |-> state == DRAIN
    );

    // a new frame must start from slot 0
    a_start_at_zero: assert property (
        @(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        state == IDLE && trig_rising |=> slot_zero
    );

endmodule

// ==== hw/timing_gen.sv ====
module timing_gen (
    input  logic                 AUDIO_CLK,
    input  logic                 reset_reg_N,
    input  logic                 slot_stb,     // one-cycle advance
    output synth_pkg::slot_idx_t slot_idx,     // slot carried by current strobe
    output logic                 slot_zero,
    output logic                 slot_top
);
    import synth_pkg::*;

    // flags straight off the count
    assign slot_zero = (slot_idx == '0);
    assign slot_top  = (slot_idx == slot_idx_t'(SLOTS - 1));

    always_ff @(posedge AUDIO_CLK)
    begin
        if (!reset_reg_N)
        begin
            slot_idx <= '0;
        end
        else if (slot_stb)
        begin
            if (slot_top)
            begin
                slot_idx <= '0;                          // wrap for next frame
            end
            else
            begin
                slot_idx <= slot_idx_t'(slot_idx + 1'b1);
            end
        end
    end

    // index must be back at 0 once the top slot has gone out
    a_top_wraps: assert property (
        @(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        slot_stb && slot_top |=> slot_zero
    );

endmodule

// ==== hw/synth_pkg.sv ====
package synth_pkg;

    localparam int SLOTS    = 8;                     // oscillator slots per frame
    localparam int SLOT_W   = 3;                     // slot index bits
    localparam int SLOT_DIV = 2;                     // clocks per slot strobe
    localparam int DIV_W    = $clog2(SLOT_DIV + 1);  // divider counter bits

    localparam int PHASE_W  = 16;                    // phase acc and increment
    localparam int LEVEL_W  = 8;                     // unsigned slot level
    localparam int SAMPLE_W = 16;                    // signed audio word
    localparam int MIX_W    = SAMPLE_W + SLOT_W;     // headroom for SLOTS adds
    localparam int PROD_W   = SAMPLE_W + LEVEL_W + 1;  // saw x signed-extended level

    typedef logic [SLOT_W-1:0]          slot_idx_t;
    typedef logic [DIV_W-1:0]           div_cnt_t;
    typedef logic [PHASE_W-1:0]         phase_t;
    typedef logic [LEVEL_W-1:0]         level_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [MIX_W-1:0]    mix_t;
    typedef logic signed [PROD_W-1:0]   prod_t;

    // config target select, one bit on the port
    typedef enum logic
    {
        CFG_INC   = 1'b0,   // phase increment
        CFG_LEVEL = 1'b1    // output level, low byte of cfg_data
    } cfg_sel_e;

    // frame state in synth_clk_gen
    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,       // waiting for trig, config open
        RUN   = 2'd1,       // strobing slots
        DRAIN = 2'd2        // pipeline flush and sample handshake
    } run_state_e;

endpackage
